// ==== rtl/fifo_cfg.svh ====
// Configuration macros for the synchronous RAM-based FIFO
// Depth, data word width and pointer index width

`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

//////////////////////////////////////////////////////////////////////////////
// Storage geometry
//////////////////////////////////////////////////////////////////////////////

// Number of entries, need not be a power of two
`define FIFO_DEPTH 13

// Bits per stored word
`define FIFO_DATA_WIDTH 16

//////////////////////////////////////////////////////////////////////////////
// Pointer geometry
//////////////////////////////////////////////////////////////////////////////

// Index bits, enough to address FIFO_DEPTH entries
// The wrapped pointer adds one wrap bit above this
`define FIFO_PTR_WIDTH 4

`endif

// ==== rtl/fifo_data_pkg.sv ====
// Data path types for the FIFO
// Stored word type shared by the RAM, the top level and the testbench

`include "fifo_cfg.svh"

package fifo_data_pkg;

    //////////////////////////////////////////////////////////////////////////
    // Data word
    //////////////////////////////////////////////////////////////////////////

    // One stored entry, as written and as read back
    typedef logic [`FIFO_DATA_WIDTH-1:0] data_word_t;

endpackage

// ==== rtl/fifo_ptr_pkg.sv ====
// Pointer and occupancy types for the FIFO
// RAM index, wrapped pointer and level

`include "fifo_cfg.svh"

package fifo_ptr_pkg;

    //////////////////////////////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////////////////////////////

    // RAM address, 0 to FIFO_DEPTH-1
    typedef logic [`FIFO_PTR_WIDTH-1:0] ptr_index_t;

    // Wrap bit on top, index below
    // Wrap bit toggles each time the index passes the last entry
    typedef logic [`FIFO_PTR_WIDTH:0] ptr_wrap_t;

    //////////////////////////////////////////////////////////////////////////
    // Occupancy
    //////////////////////////////////////////////////////////////////////////

    // Stored word count, 0 to FIFO_DEPTH inclusive
    // One bit wider than an index so the full count fits
    typedef logic [`FIFO_PTR_WIDTH:0] level_t;

endpackage

// ==== rtl/fifo_status_signal.sv ====
// Pointer and status block of the FIFO
// Wrapped write and read pointers, strobe qualification
// Full, empty and level derived from the pointer pair

`timescale 1ns/1ns

`include "fifo_cfg.svh"

module fifo_status_signal (
    input  logic                     clk,
    input  logic                     reset,
    // Strobes from outside
    input  logic                     write,
    input  logic                     read,
    // Qualified accesses toward the RAM
    output logic                     wr_en,
    output logic                     rd_en,
    output fifo_ptr_pkg::ptr_index_t wr_addr,
    output fifo_ptr_pkg::ptr_index_t rd_addr,
    // Status
    output logic                     full,
    output logic                     empty,
    output fifo_ptr_pkg::level_t     level
);

    import fifo_ptr_pkg::*;

    //////////////////////////////////////////////////////////////////////////
    // Declarations
    //////////////////////////////////////////////////////////////////////////

    // Last valid RAM index, where a pointer wraps
    localparam ptr_index_t LAST_INDEX = ptr_index_t'(`FIFO_DEPTH - 1);

    // Registered wrapped pointers
    ptr_wrap_t wr_ptr;
    ptr_wrap_t rd_ptr;

    // Pointer fields
    logic       wr_wrap;
    logic       rd_wrap;
    ptr_index_t wr_index;
    ptr_index_t rd_index;

    // Comparisons shared by the flags
    logic index_equal;
    logic wrap_equal;

    // Index difference, widened to level width
    level_t index_diff;

    //////////////////////////////////////////////////////////////////////////
    // Pointer advance
    //////////////////////////////////////////////////////////////////////////

    // Next pointer value after one accepted access
    // At the last entry the index returns to 0 and the wrap bit flips
    function automatic ptr_wrap_t advance(input ptr_wrap_t ptr);
        ptr_wrap_t nxt;
        if (ptr[`FIFO_PTR_WIDTH-1:0] == LAST_INDEX) begin
            nxt = {~ptr[`FIFO_PTR_WIDTH], {`FIFO_PTR_WIDTH{1'b0}}};
        end else begin
            // No carry into the wrap bit below the last entry
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // Field split
    //////////////////////////////////////////////////////////////////////////

    assign wr_wrap  = wr_ptr[`FIFO_PTR_WIDTH];
    assign rd_wrap  = rd_ptr[`FIFO_PTR_WIDTH];
    assign wr_index = wr_ptr[`FIFO_PTR_WIDTH-1:0];
    assign rd_index = rd_ptr[`FIFO_PTR_WIDTH-1:0];

    // RAM addresses come straight from the indices
    assign wr_addr = wr_index;
    assign rd_addr = rd_index;

    //////////////////////////////////////////////////////////////////////////
    // Flags
    //////////////////////////////////////////////////////////////////////////

    assign index_equal = (wr_index == rd_index);
    assign wrap_equal  = (wr_wrap == rd_wrap);

    // Same index, same lap
    assign empty = index_equal & wrap_equal;

    // Same index, writer one lap ahead
    assign full = index_equal & ~wrap_equal;

    //////////////////////////////////////////////////////////////////////////
    // Strobe qualification
    //////////////////////////////////////////////////////////////////////////

    // Write while full is dropped
    assign wr_en = write & ~full;

    // Read while empty is dropped
    assign rd_en = read & ~empty;

    //////////////////////////////////////////////////////////////////////////
    // Write pointer
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= advance(wr_ptr);
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Read pointer
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= advance(rd_ptr);
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Level
    //////////////////////////////////////////////////////////////////////////

    // Modulo difference, negative when the writer has wrapped
    assign index_diff = level_t'(wr_index) - level_t'(rd_index);

    // Writer a lap ahead adds one full depth to the difference
    always_comb begin
        if (wrap_equal) begin
            level = index_diff;
        end else begin
            level = level_t'(`FIFO_DEPTH) + index_diff;
        end
    end

endmodule

// ==== rtl/fifo_ram.sv ====
// FIFO storage array
// Synchronous write port, registered read port with a valid pulse

`timescale 1ns/1ns

`include "fifo_cfg.svh"

module fifo_ram (
    input  logic                     clk,
    input  logic                     reset,
    // Write port
    input  logic                     wr_en,
    input  fifo_ptr_pkg::ptr_index_t wr_addr,
    input  fifo_data_pkg::data_word_t wr_data,
    // Read port
    input  logic                     rd_en,
    input  fifo_ptr_pkg::ptr_index_t rd_addr,
    output fifo_data_pkg::data_word_t rd_data,
    output logic                     rd_valid
);

    import fifo_data_pkg::*;

    //////////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////////

    // One word per entry, addresses 0 to FIFO_DEPTH-1
    data_word_t mem [`FIFO_DEPTH];

    // Read data register
    data_word_t rd_data_q;

    // Valid flag for the read register
    logic rd_valid_q;

    //////////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////////

    // Word lands in the array on the same edge it is accepted
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////////

    // Holds the last word fetched until the next accepted read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_q <= mem[rd_addr];
        end
    end

    // High for exactly one cycle per accepted read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;
        end
    end

    assign rd_data  = rd_data_q;
    assign rd_valid = rd_valid_q;

endmodule

// ==== rtl/fifo_top.sv ====
// Top level of the synchronous RAM-based FIFO
// Pointer and status block steering the storage array

`timescale 1ns/1ns

module fifo_top (
    input  logic                      clk,
    input  logic                      reset,
    // Write side
    input  logic                      write,
    input  fifo_data_pkg::data_word_t wr_data,
    // Read side
    input  logic                      read,
    output fifo_data_pkg::data_word_t rd_data,
    output logic                      rd_valid,
    // Status
    output logic                      full,
    output logic                      empty,
    output fifo_ptr_pkg::level_t      level
);

    import fifo_ptr_pkg::*;

    //////////////////////////////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////////////////////////////

    // Qualified write access
    logic       wr_en;
    ptr_index_t wr_addr;

    // Qualified read access
    logic       rd_en;
    ptr_index_t rd_addr;

    //////////////////////////////////////////////////////////////////////////
    // Pointer and status block
    //////////////////////////////////////////////////////////////////////////

    // Turns the raw strobes into RAM enables and addresses
    fifo_status_signal i_status (
        .clk     (clk),
        .reset   (reset),
        .write   (write),
        .read    (read),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .full    (full),
        .empty   (empty),
        .level   (level)
    );

    //////////////////////////////////////////////////////////////////////////
    // Storage array
    //////////////////////////////////////////////////////////////////////////

    // Read word and valid appear one cycle after rd_en
    fifo_ram i_ram (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

// ==== dv/fifo_tb.sv ====
// Testbench for the synchronous RAM-based FIFO
// Clock, reset, directed and random stimulus, queue reference model
// Concurrent assertions against the model, watchdog and reporting

`timescale 1ns/1ns

`include "fifo_cfg.svh"

module fifo_tb;

    import fifo_data_pkg::*;
    import fifo_ptr_pkg::*;

    //////////////////////////////////////////////////////////////////////////
    // Timing and run length
    //////////////////////////////////////////////////////////////////////////

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int SETTLE_CYCLES  = 3;
    localparam int TRAFFIC_CYCLES = 600;
    localparam int PHASE_CYCLES   = 60;

    // Cycles per test, settle time included
    localparam int T1_CYCLES = 5 + SETTLE_CYCLES;
    localparam int T2_CYCLES = `FIFO_DEPTH + 5 + SETTLE_CYCLES;
    localparam int T3_CYCLES = `FIFO_DEPTH + 3 + SETTLE_CYCLES;
    localparam int T4_CYCLES = TRAFFIC_CYCLES + `FIFO_DEPTH + 2 + SETTLE_CYCLES;
    localparam int RUN_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES;

    // Margin of 100 cycles on top of the summed test lengths
    localparam int TIMEOUT_NS = (RUN_CYCLES + 100) * CLK_PERIOD;

    //////////////////////////////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////////////////////////////

    logic       clk = 1'b0;
    logic       reset;
    logic       write;
    logic       read;
    data_word_t wr_data;
    data_word_t rd_data;
    logic       rd_valid;
    logic       full;
    logic       empty;
    level_t     level;

    //////////////////////////////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////////////////////////////

    // Words in write order, oldest at the front
    data_word_t model_q[$];

    // Expected outputs, updated on each rising edge
    logic       exp_valid = 1'b0;
    data_word_t exp_data  = '0;
    level_t     exp_level = '0;

    // Accepted accesses of the current edge
    logic wr_ok;
    logic rd_ok;

    // Bookkeeping
    int error_count      = 0;
    int tests_run        = 0;
    int tests_failed     = 0;
    int test_start_errs  = 0;
    int writes_accepted  = 0;
    int both_full_count  = 0;
    int both_empty_count = 0;

    //////////////////////////////////////////////////////////////////////////
    // Clock and DUT
    //////////////////////////////////////////////////////////////////////////

    always #(CLK_PERIOD / 2) clk = ~clk;

    fifo_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .write    (write),
        .wr_data  (wr_data),
        .read     (read),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .full     (full),
        .empty    (empty),
        .level    (level)
    );

    //////////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////////

    // Acceptance judged from the model's own count, never from DUT flags
    always @(posedge clk) begin
        if (reset) begin
            model_q.delete();
            exp_valid = 1'b0;
        end else begin
            wr_ok = write && (model_q.size() < `FIFO_DEPTH);
            rd_ok = read && (model_q.size() > 0);
            if (write && read && model_q.size() == `FIFO_DEPTH) begin
                both_full_count++;
            end
            if (write && read && model_q.size() == 0) begin
                both_empty_count++;
            end
            // Popped word shows on rd_data one cycle later
            exp_valid = rd_ok;
            if (rd_ok) begin
                exp_data = model_q.pop_front();
            end
            if (wr_ok) begin
                model_q.push_back(wr_data);
                writes_accepted++;
            end
        end
        exp_level = level_t'(model_q.size());
    end

    //////////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
    endtask

    // Valid pulse follows each accepted read, never a dropped one
    valid_match: assert property (@(posedge clk) reset || rd_valid == exp_valid)
        else report_mismatch("rd_valid", 32'($sampled(exp_valid)), 32'($sampled(rd_valid)));

    // Word order against the queue
    data_match: assert property (@(posedge clk) reset || !exp_valid || rd_data == exp_data)
        else report_mismatch("rd_data", 32'($sampled(exp_data)), 32'($sampled(rd_data)));

    // Level equals the queue size every cycle
    level_match: assert property (@(posedge clk) reset || level == exp_level)
        else report_mismatch("level", 32'($sampled(exp_level)), 32'($sampled(level)));

    full_match: assert property (@(posedge clk)
        reset || full == (exp_level == level_t'(`FIFO_DEPTH)))
        else report_mismatch("full", 32'($sampled(exp_level) == level_t'(`FIFO_DEPTH)),
                             32'($sampled(full)));

    empty_match: assert property (@(posedge clk) reset || empty == (exp_level == '0))
        else report_mismatch("empty", 32'($sampled(exp_level) == '0), 32'($sampled(empty)));

    //////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////////

    // One cycle of strobes, applied just after the rising edge
    task automatic drive_cycle(input logic w, input logic r, input data_word_t d);
        @(posedge clk);
        write   <= w;
        read    <= r;
        wr_data <= d;
    endtask

    // Idle a few cycles so late checks land before the summary line
    task automatic finish_test(input string name);
        int errs;
        for (int i = 0; i < SETTLE_CYCLES - 1; i++) begin
            drive_cycle(1'b0, 1'b0, '0);
        end
        @(negedge clk);
        errs = error_count - test_start_errs;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "failed", errs);
        test_start_errs = error_count;
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////////////////////////////

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the tests did not complete", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////////

    initial begin
        int wr_pct;
        int rd_pct;
        void'($urandom(32'hf41d_f9a2));
        reset   = 1'b1;
        write   = 1'b0;
        read    = 1'b0;
        wr_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Test 1, idle after reset
        repeat (5) drive_cycle(1'b0, 1'b0, '0);
        finish_test("reset state");

        // Test 2, fill to full, then writes that must be dropped
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            drive_cycle(1'b1, 1'b0, data_word_t'($urandom));
        end
        repeat (5) drive_cycle(1'b1, 1'b0, data_word_t'($urandom));
        finish_test("fill and overflow");

        // Test 3, drain in order, then reads that must be dropped
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            drive_cycle(1'b0, 1'b1, '0);
        end
        repeat (3) drive_cycle(1'b0, 1'b1, '0);
        finish_test("drain and underflow");

        // Test 4, random traffic in phases of shifting bias
        // Write-heavy phases reach full, read-heavy ones reach empty
        for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
            case ((i / PHASE_CYCLES) % 3)
                0: begin
                    wr_pct = 90;
                    rd_pct = 30;
                end
                1: begin
                    wr_pct = 30;
                    rd_pct = 90;
                end
                default: begin
                    wr_pct = 60;
                    rd_pct = 60;
                end
            endcase
            drive_cycle(($urandom % 100) < wr_pct, ($urandom % 100) < rd_pct,
                        data_word_t'($urandom));
        end
        // Empty out what is left
        repeat (`FIFO_DEPTH + 2) drive_cycle(1'b0, 1'b1, '0);
        if (both_full_count == 0) begin
            error_count++;
            $display("Random traffic never had read and write together while full");
        end
        if (both_empty_count == 0) begin
            error_count++;
            $display("Random traffic never had read and write together while empty");
        end
        if (writes_accepted < 5 * `FIFO_DEPTH) begin
            error_count++;
            $display("Random traffic wrapped the pointers too few times");
        end
        finish_test("random traffic");

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/fifo_data_pkg.sv
rtl/fifo_ptr_pkg.sv
rtl/fifo_status_signal.sv
rtl/fifo_ram.sv
rtl/fifo_top.sv
dv/fifo_tb.sv

// ==== Makefile ====
# Verilator build and run of the FIFO testbench

TOP := fifo_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)
